// ==== flist.f ====
+incdir+tb
verilog/idu_pkg.sv
verilog/idu_op_decode.sv
verilog/idu_imm_gen.sv
verilog/idu_field_select.sv
verilog/riscv_idu.sv
tb/tb_idu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the IDU testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_idu -f flist.f -o sim_idu || exit 1
out="$(./obj_dir/sim_idu)"
echo "$out"
echo "$out" | grep -q "Done: no errors" && exit 0 || exit 1

// ==== tb/idu_model.svh ====
// Expected DUT outputs for one fetched word
typedef struct packed {
  logic        vld;
  idu_op_t     op;
  logic [6:0]  opcode;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm;
  logic [4:0]  shamt;
  logic [11:0] csr;
  logic [3:0]  fm;
  logic [3:0]  pred;
  logic [3:0]  succ;
} expect_t;

function automatic idu_op_t model_op(input logic [31:0] w);
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = w[14:12];
  f7 = w[31:25];
  case (w[6:0])
    op_lui:      return lui;
    op_auipc:    return auipc;
    op_jal:      return jal;
    op_jalr:     return jalr;
    op_misc_mem: return fence;
    op_branch: begin
      if (f3 == 3'd2 || f3 == 3'd3) return op_none;
      return idu_op_t'(6'(int'(beq) + (f3 > 3'd3 ? int'(f3) - 2 : int'(f3))));
    end
    op_load: begin
      if (f3 == 3'd3 || f3 > 3'd5) return op_none;
      return idu_op_t'(6'(int'(lb) + (f3 > 3'd3 ? int'(f3) - 1 : int'(f3))));
    end
    op_store: return (f3 > 3'd2) ? op_none : idu_op_t'(6'(int'(sb) + int'(f3)));
    op_imm: begin
      if (f3 == 3'd1) return slli;
      if (f3 == 3'd5) return (f7 == f7_base) ? srli : (f7 == f7_alt) ? srai : op_none;
      // addi .. andi sit at funct3 0, 2, 3, 4, 6, 7
      return idu_op_t'(6'(int'(addi) +
                          (f3 == 3'd0 ? 0 : f3 < 3'd5 ? int'(f3) - 1 : int'(f3) - 2)));
    end
    op_reg: begin
      if (f3 == 3'd0) return (f7 == f7_base) ? add : (f7 == f7_alt) ? sub : op_none;
      if (f3 == 3'd5) return (f7 == f7_base) ? srl : (f7 == f7_alt) ? sra : op_none;
      return idu_op_t'(6'(int'(sll) + (f3 < 3'd5 ? int'(f3) - 1 : int'(f3))));
    end
    op_system: begin
      if (f3 == 3'd0) return w[20] ? ebreak : ecall;
      if (f3 == 3'd4) return ecall;
      return idu_op_t'(6'(int'(csrrw) + (f3 < 3'd4 ? int'(f3) - 1 : int'(f3) - 2)));
    end
    default: return op_none;
  endcase
endfunction

function automatic expect_t model_expect(input logic v, input logic [31:0] w);
  expect_t e;
  idu_op_t o;
  logic    is_b;
  logic    is_s;
  logic    is_sh;
  logic    is_r;
  logic    is_u;
  logic    is_i;
  o      = model_op(w);
  e      = '0;
  e.vld  = v;
  e.op   = o;
  e.opcode = w[6:0];
  if (o == op_none || o == ecall || o == ebreak) return e; // No operand fields
  is_b  = (o >= beq && o <= bgeu);
  is_s  = (o >= sb && o <= sw);
  is_sh = (o >= slli && o <= srai);
  is_r  = (o >= add && o <= and_op);
  is_u  = (o == lui || o == auipc);
  is_i  = (o == jalr || (o >= lb && o <= lhu) || (o >= addi && o <= andi));
  if (!is_b && !is_s) e.rd = w[11:7];
  if (!is_u && o != jal) begin
    e.rs1    = w[19:15];
    e.funct3 = w[14:12];
  end
  if (is_r || is_s || is_b) e.rs2 = w[24:20];
  if (is_r || is_sh) e.funct7 = w[31:25];
  if (is_i) e.imm = {20'd0, w[31:20]};
  if (is_s) e.imm = {20'd0, w[31:25], w[11:7]};
  if (is_b) e.imm = {19'd0, w[31], w[7], w[30:25], w[11:8], 1'b0};
  if (is_u) e.imm = {w[31:12], 12'd0};
  if (o == jal) e.imm = {11'd0, w[31], w[19:12], w[20], w[30:21], 1'b0};
  if (is_sh) e.shamt = w[24:20];
  if (o >= csrrw) e.csr = w[31:20];
  if (o == fence) {e.fm, e.pred, e.succ} = w[31:20];
  return e;
endfunction

// Major opcode of each operation class
function automatic logic [6:0] class_opcode(input idu_op_t o);
  case (o)
    lui:   return op_lui;
    auipc: return op_auipc;
    jal:   return op_jal;
    jalr:  return op_jalr;
    beq, bne, blt, bge, bltu, bgeu: return op_branch;
    lb, lh, lw, lbu, lhu: return op_load;
    sb, sh, sw: return op_store;
    addi, slti, sltiu, xori, ori, andi, slli, srli, srai: return op_imm;
    fence: return op_misc_mem;
    ecall, ebreak, csrrw, csrrs, csrrc, csrrwi, csrrsi, csrrci: return op_system;
    default: return op_reg;
  endcase
endfunction

// Search funct3, bit 20 and funct7 from a random start until the word decodes as o
function automatic logic [31:0] encode_op(input idu_op_t o, input logic [31:0] r);
  logic [31:0] w;
  int          k;
  w      = r;
  w[6:0] = class_opcode(o);
  for (int i = 0; i < 48; i++) begin
    k        = (i + int'(r[5:0])) % 48;
    w[14:12] = k[2:0];
    w[20]    = k[3];
    if (k >= 32) w[31:25] = r[31:25];
    else if (k >= 16) w[31:25] = f7_alt;
    else w[31:25] = f7_base;
    if (model_op(w) == o) return w;
  end
  return w;
endfunction

// ==== tb/tb_idu.sv ====
`timescale 1ns/100ps

module tb_idu;
  import idu_pkg::*;

  `include "idu_model.svh"

  localparam int num_words  = 2000;
  localparam int max_cycles = num_words + 50;

  logic                  clk;
  logic                  rst_n;
  logic                  ifu_vld;
  logic [xlen-1:0]       ifu_inst;
  logic                  idu_vld;
  idu_op_t               op;
  logic [6:0]            opcode;
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [xlen-1:0]       imm;
  logic [4:0]            shamt;
  logic [11:0]           csr;
  logic [3:0]            fm;
  logic [3:0]            pred;
  logic [3:0]            succ;

  integer      seed;
  int          errors;
  int          cycles;
  int          n;
  int          b;
  logic        v;
  logic [31:0] r;
  logic [31:0] w;
  expect_t     pend; // Expectation for the word now in the output register

  riscv_idu u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .ifu_vld  (ifu_vld),
    .ifu_inst (ifu_inst),
    .idu_vld  (idu_vld),
    .op       (op),
    .opcode   (opcode),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .funct3   (funct3),
    .funct7   (funct7),
    .imm      (imm),
    .shamt    (shamt),
    .csr      (csr),
    .fm       (fm),
    .pred     (pred),
    .succ     (succ)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic compare_outputs(input expect_t e);
    check_value("idu_vld", 32'(idu_vld), 32'(e.vld));
    check_value("op", 32'(op), 32'(e.op));
    check_value("opcode", 32'(opcode), 32'(e.opcode));
    check_value("rd", 32'(rd), 32'(e.rd));
    check_value("rs1", 32'(rs1), 32'(e.rs1));
    check_value("rs2", 32'(rs2), 32'(e.rs2));
    check_value("funct3", 32'(funct3), 32'(e.funct3));
    check_value("funct7", 32'(funct7), 32'(e.funct7));
    check_value("imm", imm, e.imm);
    check_value("shamt", 32'(shamt), 32'(e.shamt));
    check_value("csr", 32'(csr), 32'(e.csr));
    check_value("fm", 32'(fm), 32'(e.fm));
    check_value("pred", 32'(pred), 32'(e.pred));
    check_value("succ", 32'(succ), 32'(e.succ));
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Done: errors found");
    $fatal(1, "Timeout");
  endtask

  initial begin
    seed     = 48;
    errors   = 0;
    cycles   = 0;
    rst_n    = 1'b0;
    ifu_vld  = 1'b0;
    ifu_inst = '0;

    // Reset for 5 rising edges, outputs must stay cleared
    while (!rst_n) begin
      @(negedge clk);
      compare_outputs('0);
      @(posedge clk);
      cycles++;
      if (cycles == 5) rst_n <= 1'b1;
      if (cycles > 20) timeout_fail("reset release");
    end

    pend   = model_expect(1'b0, '0); // Word captured on the release edge
    n      = 0;
    cycles = 0;
    while (n < num_words) begin
      v = (($random(seed) & 3) != 0); // About one gap in four
      r = $random(seed);
      if (($random(seed) & 7) < 5) begin
        w = encode_op(idu_op_t'(6'(1 + {$random(seed)} % 46)), r);
        if (($random(seed) & 3) == 0) begin
          // Flip one of funct3, bit 20 or funct7 for boundary cases
          b    = {$random(seed)} % 11;
          b    = (b < 3) ? 12 + b : (b == 3) ? 20 : 21 + b;
          w[b] = ~w[b];
        end
      end else begin
        w = r;
      end
      ifu_vld  <= v;
      ifu_inst <= w;
      @(negedge clk);
      compare_outputs(pend);
      pend = model_expect(v, w);
      @(posedge clk);
      n++;
      cycles++;
      if (cycles > max_cycles) timeout_fail("end of stimulus");
    end
    @(negedge clk);
    compare_outputs(pend);

    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verilog/idu_field_select.sv ====
`timescale 1ns/100ps

module idu_field_select (
  input  logic [idu_pkg::xlen-1:0]       inst,
  input  idu_pkg::idu_fmt_t              fmt,
  output logic [idu_pkg::reg_addr_w-1:0] rd,
  output logic [idu_pkg::reg_addr_w-1:0] rs1,
  output logic [idu_pkg::reg_addr_w-1:0] rs2,
  output logic [2:0]                     funct3,
  output logic [6:0]                     funct7
);
  import idu_pkg::*;

  logic has_rd;
  logic has_rs1;
  logic has_rs2;
  logic has_f7;

  always_comb begin
    has_rd  = 1'b0;
    has_rs1 = 1'b0;
    has_rs2 = 1'b0;
    has_f7  = 1'b0;
    case (fmt)
      fmt_r: begin
        has_rd  = 1'b1;
        has_rs1 = 1'b1;
        has_rs2 = 1'b1;
        has_f7  = 1'b1;
      end
      fmt_i, fmt_fence, fmt_csr: begin
        has_rd  = 1'b1;
        has_rs1 = 1'b1;
      end
      fmt_ish: begin
        has_rd  = 1'b1;
        has_rs1 = 1'b1;
        has_f7  = 1'b1;
      end
      fmt_s, fmt_b: begin
        has_rs1 = 1'b1;
        has_rs2 = 1'b1;
      end
      fmt_u, fmt_j: has_rd = 1'b1;
      default: has_rd = 1'b0;
    endcase
  end

  assign rd     = has_rd  ? inst[11:7]  : '0;
  assign rs1    = has_rs1 ? inst[19:15] : '0; // Also the CSR uimm
  assign funct3 = has_rs1 ? inst[14:12] : '0; // Travels with rs1
  assign rs2    = has_rs2 ? inst[24:20] : '0;
  assign funct7 = has_f7  ? inst[31:25] : '0;

endmodule

// ==== verilog/idu_imm_gen.sv ====
`timescale 1ns/100ps

module idu_imm_gen (
  input  logic [idu_pkg::xlen-1:0] inst,
  input  idu_pkg::idu_fmt_t        fmt,
  output logic [idu_pkg::xlen-1:0] imm,
  output logic [4:0]               shamt,
  output logic [11:0]              csr,
  output logic [3:0]               fm,
  output logic [3:0]               pred,
  output logic [3:0]               succ
);
  import idu_pkg::*;

  // Bits land at their architectural positions without sign extension
  always_comb begin
    imm   = '0;
    shamt = '0;
    csr   = '0;
    fm    = '0;
    pred  = '0;
    succ  = '0;
    case (fmt)
      fmt_i: imm[11:0] = inst[31:20];
      fmt_s: begin
        imm[11:5] = inst[31:25];
        imm[4:0]  = inst[11:7];
      end
      fmt_b: begin
        imm[12]   = inst[31];
        imm[11]   = inst[7];
        imm[10:5] = inst[30:25];
        imm[4:1]  = inst[11:8];
      end
      fmt_u: imm[31:12] = inst[31:12];
      fmt_j: begin
        imm[20]    = inst[31];
        imm[19:12] = inst[19:12];
        imm[11]    = inst[20];
        imm[10:1]  = inst[30:21];
      end
      fmt_ish: shamt = inst[24:20];
      fmt_csr: csr = inst[31:20];
      fmt_fence: begin
        fm   = inst[31:28];
        pred = inst[27:24];
        succ = inst[23:20];
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/idu_op_decode.sv ====
`timescale 1ns/100ps

module idu_op_decode (
  input  logic [idu_pkg::xlen-1:0] inst,
  output idu_pkg::idu_op_t         op,
  output idu_pkg::idu_fmt_t        fmt
);
  import idu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    op  = op_none;
    fmt = fmt_none;
    case (opcode)
      op_lui: begin
        op  = lui;
        fmt = fmt_u;
      end
      op_auipc: begin
        op  = auipc;
        fmt = fmt_u;
      end
      op_jal: begin
        op  = jal;
        fmt = fmt_j;
      end
      op_jalr: begin
        op  = jalr; // funct3 not checked
        fmt = fmt_i;
      end
      op_branch: begin
        fmt = fmt_b;
        case (funct3)
          3'b000: op = beq;
          3'b001: op = bne;
          3'b100: op = blt;
          3'b101: op = bge;
          3'b110: op = bltu;
          3'b111: op = bgeu;
          default: op = op_none;
        endcase
      end
      op_load: begin
        fmt = fmt_i;
        case (funct3)
          3'b000: op = lb;
          3'b001: op = lh;
          3'b010: op = lw;
          3'b100: op = lbu;
          3'b101: op = lhu;
          default: op = op_none;
        endcase
      end
      op_store: begin
        fmt = fmt_s;
        case (funct3)
          3'b000: op = sb;
          3'b001: op = sh;
          3'b010: op = sw;
          default: op = op_none;
        endcase
      end
      op_imm: begin
        fmt = fmt_i;
        case (funct3)
          3'b000: op = addi;
          3'b010: op = slti;
          3'b011: op = sltiu;
          3'b100: op = xori;
          3'b110: op = ori;
          3'b111: op = andi;
          3'b001: begin
            op  = slli; // Any funct7
            fmt = fmt_ish;
          end
          default: begin
            fmt = fmt_ish;
            case (funct7)
              f7_base: op = srli;
              f7_alt:  op = srai;
              default: op = op_none;
            endcase
          end
        endcase
      end
      op_reg: begin
        fmt = fmt_r;
        case (funct3)
          3'b000: op = (funct7 == f7_base) ? add : (funct7 == f7_alt) ? sub : op_none;
          3'b001: op = sll;
          3'b010: op = slt;
          3'b011: op = sltu;
          3'b100: op = xor_op;
          3'b101: op = (funct7 == f7_base) ? srl : (funct7 == f7_alt) ? sra : op_none;
          3'b110: op = or_op;
          default: op = and_op;
        endcase
      end
      op_misc_mem: begin
        op  = fence; // Any funct3
        fmt = fmt_fence;
      end
      op_system: begin
        fmt = fmt_csr;
        case (funct3)
          3'b001: op = csrrw;
          3'b010: op = csrrs;
          3'b011: op = csrrc;
          3'b101: op = csrrwi;
          3'b110: op = csrrsi;
          3'b111: op = csrrci;
          default: begin
            op  = (funct3 == 3'b000 && inst[20]) ? ebreak : ecall;
            fmt = fmt_sys;
          end
        endcase
      end
      default: op = op_none;
    endcase
    if (op == op_none) fmt = fmt_none; // Illegal word carries no fields
  end

endmodule

// ==== verilog/idu_pkg.sv ====
package idu_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // Major opcodes from inst[6:0]
  localparam logic [6:0] op_lui      = 7'b0110111;
  localparam logic [6:0] op_auipc    = 7'b0010111;
  localparam logic [6:0] op_jal      = 7'b1101111;
  localparam logic [6:0] op_jalr     = 7'b1100111;
  localparam logic [6:0] op_branch   = 7'b1100011;
  localparam logic [6:0] op_load     = 7'b0000011;
  localparam logic [6:0] op_store    = 7'b0100011;
  localparam logic [6:0] op_imm      = 7'b0010011;
  localparam logic [6:0] op_reg      = 7'b0110011;
  localparam logic [6:0] op_misc_mem = 7'b0001111;
  localparam logic [6:0] op_system   = 7'b1110011;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // SUB, SRA, SRAI

  typedef enum logic [5:0] {
    op_none,
    lui,
    auipc,
    jal,
    jalr,
    beq,
    bne,
    blt,
    bge,
    bltu,
    bgeu,
    lb,
    lh,
    lw,
    lbu,
    lhu,
    sb,
    sh,
    sw,
    addi,
    slti,
    sltiu,
    xori,
    ori,
    andi,
    slli,
    srli,
    srai,
    add,
    sub,
    sll,
    slt,
    sltu,
    xor_op, // Avoids keyword clash
    srl,
    sra,
    or_op,
    and_op,
    fence,
    ecall,
    ebreak,
    csrrw,
    csrrs,
    csrrc,
    csrrwi,
    csrrsi,
    csrrci
  } idu_op_t;

  // Which operand fields an instruction carries
  typedef enum logic [3:0] {
    fmt_none,
    fmt_r,
    fmt_i,
    fmt_ish,   // I-type with shamt and funct7
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j,
    fmt_fence,
    fmt_csr,
    fmt_sys    // ECALL, EBREAK
  } idu_fmt_t;

endpackage

// ==== verilog/riscv_idu.sv ====
`timescale 1ns/100ps

module riscv_idu (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           ifu_vld,
  input  logic [idu_pkg::xlen-1:0]       ifu_inst,
  output logic                           idu_vld,
  output idu_pkg::idu_op_t               op,
  output logic [6:0]                     opcode,
  output logic [idu_pkg::reg_addr_w-1:0] rd,
  output logic [idu_pkg::reg_addr_w-1:0] rs1,
  output logic [idu_pkg::reg_addr_w-1:0] rs2,
  output logic [2:0]                     funct3,
  output logic [6:0]                     funct7,
  output logic [idu_pkg::xlen-1:0]       imm,
  output logic [4:0]                     shamt,
  output logic [11:0]                    csr,
  output logic [3:0]                     fm,
  output logic [3:0]                     pred,
  output logic [3:0]                     succ
);
  import idu_pkg::*;

  idu_op_t               op_c;
  idu_fmt_t              fmt_c;
  logic [xlen-1:0]       imm_c;
  logic [4:0]            shamt_c;
  logic [11:0]           csr_c;
  logic [3:0]            fm_c;
  logic [3:0]            pred_c;
  logic [3:0]            succ_c;
  logic [reg_addr_w-1:0] rd_c;
  logic [reg_addr_w-1:0] rs1_c;
  logic [reg_addr_w-1:0] rs2_c;
  logic [2:0]            funct3_c;
  logic [6:0]            funct7_c;

  idu_op_decode u_op_decode (
    .inst (ifu_inst),
    .op   (op_c),
    .fmt  (fmt_c)
  );

  idu_imm_gen u_imm_gen (
    .inst  (ifu_inst),
    .fmt   (fmt_c),
    .imm   (imm_c),
    .shamt (shamt_c),
    .csr   (csr_c),
    .fm    (fm_c),
    .pred  (pred_c),
    .succ  (succ_c)
  );

  idu_field_select u_field_select (
    .inst   (ifu_inst),
    .fmt    (fmt_c),
    .rd     (rd_c),
    .rs1    (rs1_c),
    .rs2    (rs2_c),
    .funct3 (funct3_c),
    .funct7 (funct7_c)
  );

  // Loads every cycle, fields only meaningful with idu_vld
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idu_vld <= 1'b0;
      op      <= op_none;
      opcode  <= '0;
      rd      <= '0;
      rs1     <= '0;
      rs2     <= '0;
      funct3  <= '0;
      funct7  <= '0;
      imm     <= '0;
      shamt   <= '0;
      csr     <= '0;
      fm      <= '0;
      pred    <= '0;
      succ    <= '0;
    end else begin
      idu_vld <= ifu_vld;
      op      <= op_c;
      opcode  <= ifu_inst[6:0]; // Raw, even for op_none
      rd      <= rd_c;
      rs1     <= rs1_c;
      rs2     <= rs2_c;
      funct3  <= funct3_c;
      funct7  <= funct7_c;
      imm     <= imm_c;
      shamt   <= shamt_c;
      csr     <= csr_c;
      fm      <= fm_c;
      pred    <= pred_c;
      succ    <= succ_c;
    end
  end

endmodule
